// ==== source/dct_pkg.sv ====
// Shared widths, types and constants for the 8-point forward DCT row pass
`default_nettype none

package dct_pkg;

	// Unsigned luminance sample straight from the pixel stream
	typedef logic [7:0] pixel_t;

	// DCT matrix entries carry 14 fraction bits
	typedef logic signed [14:0] weight_t;
	typedef logic signed [24:0] prod_t;
	typedef logic signed [24:0] acc_t;

	// Coefficient after the 12 fraction bits are dropped
	typedef logic signed [12:0] coef_t;

	// Column or row position inside the 8x8 block
	typedef logic [2:0] idx_t;

	localparam int BLOCK_DIM = 8;

	// Half of cos(k*pi/16) scaled by 2^14
	localparam weight_t W_C1 = 15'sd8035;
	localparam weight_t W_C2 = 15'sd7568;
	localparam weight_t W_C3 = 15'sd6811;
	localparam weight_t W_C4 = 15'sd5793;
	localparam weight_t W_C5 = 15'sd4551;
	localparam weight_t W_C6 = 15'sd3135;
	localparam weight_t W_C7 = 15'sd1598;

	// 128 * 8 * W_C4, which centres the DC term without touching each pixel
	localparam acc_t LEVEL_SHIFT_SUM = 25'sd5932032;

	localparam int FRAC_BITS = 12;

	typedef enum logic [1:0] {
		IDLE,
		STREAM,
		DRAIN
	} seq_state_t;

endpackage

`default_nettype wire

// ==== source/pixel_counter.sv ====
// Column and row position of the incoming pixel inside the 8x8 block
`timescale 1ns/100ps
`default_nettype none

module pixel_counter (
	input  logic          clk,
	input  logic          rst,
	input  logic          enable,
	output dct_pkg::idx_t col_idx,
	output dct_pkg::idx_t row_idx
);

	logic last_col;
	logic last_row;

	assign last_col = (col_idx == dct_pkg::idx_t'(dct_pkg::BLOCK_DIM - 1));
	assign last_row = (row_idx == dct_pkg::idx_t'(dct_pkg::BLOCK_DIM - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			col_idx <= '0;
			row_idx <= '0;
		end else if (!enable) begin
			// A gap in the stream drops any partial row and restarts the block
			col_idx <= '0;
			row_idx <= '0;
		end else begin
			if (last_col) begin
				col_idx <= '0;
			end else begin
				col_idx <= col_idx + 1'b1;
			end
			if (last_col) begin
				if (last_row) begin
					row_idx <= '0;
				end else begin
					row_idx <= row_idx + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/row_sequencer.sv ====
// Tags each sampled pixel through the two pipeline stages and
// produces load, row_valid, row_index and busy
`timescale 1ns/100ps
`default_nettype none

module row_sequencer (
	input  logic          clk,
	input  logic          rst,
	input  logic          enable,
	input  dct_pkg::idx_t col_idx,
	input  dct_pkg::idx_t row_idx,
	output logic          first_tag,
	output logic          load,
	output logic          row_valid,
	output dct_pkg::idx_t row_index,
	output logic          busy
);

	dct_pkg::seq_state_t state;
	dct_pkg::seq_state_t next_state;

	// Stage 1 lines up with the product registers, stage 2 with the accumulators
	logic          s1_valid;
	logic          s1_first;
	logic          s1_last;
	dct_pkg::idx_t s1_row;
	logic          s2_valid;
	logic          s2_last;
	dct_pkg::idx_t s2_row;
	logic          in_flight;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s1_first <= 1'b0;
			s1_last  <= 1'b0;
			s1_row   <= '0;
			s2_valid <= 1'b0;
			s2_last  <= 1'b0;
			s2_row   <= '0;
		end else begin
			s1_valid <= enable;
			s1_first <= enable && (col_idx == '0);
			s1_last  <= enable && (col_idx == dct_pkg::idx_t'(dct_pkg::BLOCK_DIM - 1));
			s1_row   <= row_idx;
			s2_valid <= s1_valid;
			s2_last  <= s1_last;
			s2_row   <= s1_row;
		end
	end

	assign first_tag = s1_first;
	assign load      = s2_valid && s2_last;
	assign in_flight = s1_valid || s2_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			row_valid <= 1'b0;
			row_index <= '0;
		end else begin
			row_valid <= load;
			if (load) begin
				row_index <= s2_row;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			dct_pkg::IDLE: begin
				if (enable) next_state = dct_pkg::STREAM;
			end
			dct_pkg::STREAM: begin
				if (!enable) next_state = in_flight ? dct_pkg::DRAIN : dct_pkg::IDLE;
			end
			dct_pkg::DRAIN: begin
				if (enable) next_state = dct_pkg::STREAM;
				else if (!in_flight) next_state = dct_pkg::IDLE;
			end
			default: next_state = dct_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dct_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign busy = (state != dct_pkg::IDLE);

endmodule

`default_nettype wire

// ==== source/dct_weight_table.sv ====
// DCT-II matrix column lookup: the eight row weights that multiply the pixel at col_idx
`timescale 1ns/100ps
`default_nettype none

module dct_weight_table (
	input  dct_pkg::idx_t    col_idx,
	output dct_pkg::weight_t weight_0,
	output dct_pkg::weight_t weight_1,
	output dct_pkg::weight_t weight_2,
	output dct_pkg::weight_t weight_3,
	output dct_pkg::weight_t weight_4,
	output dct_pkg::weight_t weight_5,
	output dct_pkg::weight_t weight_6,
	output dct_pkg::weight_t weight_7
);

	function automatic dct_pkg::weight_t magnitude(input int f);
		case (f)
			1: return dct_pkg::W_C1;
			2: return dct_pkg::W_C2;
			3: return dct_pkg::W_C3;
			4: return dct_pkg::W_C4;
			5: return dct_pkg::W_C5;
			6: return dct_pkg::W_C6;
			7: return dct_pkg::W_C7;
			default: return '0;
		endcase
	endfunction

	// Folds the angle (2n+1)k*pi/16 into the first quadrant to pick sign and magnitude
	function automatic dct_pkg::weight_t entry(input dct_pkg::idx_t n, input int k);
		int p;
		int f;
		logic neg;
		p = ((2 * int'(n) + 1) * k) % 32;
		if (p < 8) begin
			f = p;
			neg = 1'b0;
		end else if (p < 16) begin
			f = 16 - p;
			neg = 1'b1;
		end else if (p < 24) begin
			f = p - 16;
			neg = 1'b1;
		end else begin
			f = 32 - p;
			neg = 1'b0;
		end
		if (k == 0) return dct_pkg::W_C4;
		return neg ? -magnitude(f) : magnitude(f);
	endfunction

	assign weight_0 = entry(col_idx, 0);
	assign weight_1 = entry(col_idx, 1);
	assign weight_2 = entry(col_idx, 2);
	assign weight_3 = entry(col_idx, 3);
	assign weight_4 = entry(col_idx, 4);
	assign weight_5 = entry(col_idx, 5);
	assign weight_6 = entry(col_idx, 6);
	assign weight_7 = entry(col_idx, 7);

endmodule

`default_nettype wire

// ==== source/mac_bank.sv ====
// Eight multiply-accumulate lanes, one per DCT row of the matrix
`timescale 1ns/100ps
`default_nettype none

module mac_bank (
	input  logic             clk,
	input  logic             rst,
	input  logic             enable,
	input  logic             first_tag,
	input  dct_pkg::pixel_t  data_in,
	input  dct_pkg::weight_t weight_0,
	input  dct_pkg::weight_t weight_1,
	input  dct_pkg::weight_t weight_2,
	input  dct_pkg::weight_t weight_3,
	input  dct_pkg::weight_t weight_4,
	input  dct_pkg::weight_t weight_5,
	input  dct_pkg::weight_t weight_6,
	input  dct_pkg::weight_t weight_7,
	output dct_pkg::acc_t    sum_0,
	output dct_pkg::acc_t    sum_1,
	output dct_pkg::acc_t    sum_2,
	output dct_pkg::acc_t    sum_3,
	output dct_pkg::acc_t    sum_4,
	output dct_pkg::acc_t    sum_5,
	output dct_pkg::acc_t    sum_6,
	output dct_pkg::acc_t    sum_7
);

	dct_pkg::weight_t weight [dct_pkg::BLOCK_DIM];
	dct_pkg::prod_t   prod   [dct_pkg::BLOCK_DIM];
	dct_pkg::acc_t    acc    [dct_pkg::BLOCK_DIM];
	logic             prod_valid;

	assign weight[0] = weight_0;
	assign weight[1] = weight_1;
	assign weight[2] = weight_2;
	assign weight[3] = weight_3;
	assign weight[4] = weight_4;
	assign weight[5] = weight_5;
	assign weight[6] = weight_6;
	assign weight[7] = weight_7;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= enable;
		end
	end

	// The pixel is unsigned, so it gets a zero sign bit before the signed multiply
	always_ff @(posedge clk) begin
		for (int i = 0; i < dct_pkg::BLOCK_DIM; i++) begin
			if (enable) begin
				prod[i] <= $signed({1'b0, data_in}) * weight[i];
			end
			if (first_tag) begin
				acc[i] <= prod[i];
			end else if (prod_valid) begin
				acc[i] <= acc[i] + prod[i];
			end
		end
	end

	assign sum_0 = acc[0];
	assign sum_1 = acc[1];
	assign sum_2 = acc[2];
	assign sum_3 = acc[3];
	assign sum_4 = acc[4];
	assign sum_5 = acc[5];
	assign sum_6 = acc[6];
	assign sum_7 = acc[7];

endmodule

`default_nettype wire

// ==== source/coef_round.sv ====
// Removes the level shift from the DC sum, rounds all eight row sums
// to integer coefficients and holds them at the outputs
`timescale 1ns/100ps
`default_nettype none

module coef_round (
	input  logic           clk,
	input  logic           rst,
	input  logic           load,
	input  dct_pkg::acc_t  sum_0,
	input  dct_pkg::acc_t  sum_1,
	input  dct_pkg::acc_t  sum_2,
	input  dct_pkg::acc_t  sum_3,
	input  dct_pkg::acc_t  sum_4,
	input  dct_pkg::acc_t  sum_5,
	input  dct_pkg::acc_t  sum_6,
	input  dct_pkg::acc_t  sum_7,
	output dct_pkg::coef_t coef_0,
	output dct_pkg::coef_t coef_1,
	output dct_pkg::coef_t coef_2,
	output dct_pkg::coef_t coef_3,
	output dct_pkg::coef_t coef_4,
	output dct_pkg::coef_t coef_5,
	output dct_pkg::coef_t coef_6,
	output dct_pkg::coef_t coef_7
);

	dct_pkg::acc_t  sums   [dct_pkg::BLOCK_DIM];
	dct_pkg::coef_t coef_q [dct_pkg::BLOCK_DIM];

	// Floor of the shifted sum, plus one when the first dropped bit is set
	function automatic dct_pkg::coef_t round_half(input dct_pkg::acc_t s);
		dct_pkg::acc_t q;
		q = s >>> dct_pkg::FRAC_BITS;
		return dct_pkg::coef_t'(q) + dct_pkg::coef_t'(s[dct_pkg::FRAC_BITS - 1]);
	endfunction

	// Only the DC lane needs the shift; the other matrix rows sum to zero
	assign sums[0] = sum_0 - dct_pkg::LEVEL_SHIFT_SUM;
	assign sums[1] = sum_1;
	assign sums[2] = sum_2;
	assign sums[3] = sum_3;
	assign sums[4] = sum_4;
	assign sums[5] = sum_5;
	assign sums[6] = sum_6;
	assign sums[7] = sum_7;

	always_ff @(posedge clk) begin
		for (int i = 0; i < dct_pkg::BLOCK_DIM; i++) begin
			if (rst) begin
				coef_q[i] <= '0;
			end else if (load) begin
				coef_q[i] <= round_half(sums[i]);
			end
		end
	end

	assign coef_0 = coef_q[0];
	assign coef_1 = coef_q[1];
	assign coef_2 = coef_q[2];
	assign coef_3 = coef_q[3];
	assign coef_4 = coef_q[4];
	assign coef_5 = coef_q[5];
	assign coef_6 = coef_q[6];
	assign coef_7 = coef_q[7];

endmodule

`default_nettype wire

// ==== source/dct_row_top.sv ====
// Row pass of the 8x8 forward DCT for the luminance path,
// one pixel per clock in and eight coefficients per row out
`timescale 1ns/100ps
`default_nettype none

module dct_row_top (
	input  logic            clk,
	input  logic            rst,
	input  logic            enable,
	input  dct_pkg::pixel_t data_in,
	output dct_pkg::coef_t  coef_0,
	output dct_pkg::coef_t  coef_1,
	output dct_pkg::coef_t  coef_2,
	output dct_pkg::coef_t  coef_3,
	output dct_pkg::coef_t  coef_4,
	output dct_pkg::coef_t  coef_5,
	output dct_pkg::coef_t  coef_6,
	output dct_pkg::coef_t  coef_7,
	output logic            row_valid,
	output dct_pkg::idx_t   row_index,
	output logic            busy
);

	dct_pkg::idx_t    col_idx;
	dct_pkg::idx_t    row_idx;
	logic             first_tag;
	logic             load;
	dct_pkg::weight_t weight_0, weight_1, weight_2, weight_3;
	dct_pkg::weight_t weight_4, weight_5, weight_6, weight_7;
	dct_pkg::acc_t    sum_0, sum_1, sum_2, sum_3;
	dct_pkg::acc_t    sum_4, sum_5, sum_6, sum_7;

	pixel_counter u_pixel_counter (
		.clk     (clk),
		.rst     (rst),
		.enable  (enable),
		.col_idx (col_idx),
		.row_idx (row_idx)
	);

	row_sequencer u_row_sequencer (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.col_idx   (col_idx),
		.row_idx   (row_idx),
		.first_tag (first_tag),
		.load      (load),
		.row_valid (row_valid),
		.row_index (row_index),
		.busy      (busy)
	);

	dct_weight_table u_dct_weight_table (
		.col_idx  (col_idx),
		.weight_0 (weight_0),
		.weight_1 (weight_1),
		.weight_2 (weight_2),
		.weight_3 (weight_3),
		.weight_4 (weight_4),
		.weight_5 (weight_5),
		.weight_6 (weight_6),
		.weight_7 (weight_7)
	);

	mac_bank u_mac_bank (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.first_tag (first_tag),
		.data_in   (data_in),
		.weight_0  (weight_0),
		.weight_1  (weight_1),
		.weight_2  (weight_2),
		.weight_3  (weight_3),
		.weight_4  (weight_4),
		.weight_5  (weight_5),
		.weight_6  (weight_6),
		.weight_7  (weight_7),
		.sum_0     (sum_0),
		.sum_1     (sum_1),
		.sum_2     (sum_2),
		.sum_3     (sum_3),
		.sum_4     (sum_4),
		.sum_5     (sum_5),
		.sum_6     (sum_6),
		.sum_7     (sum_7)
	);

	coef_round u_coef_round (
		.clk    (clk),
		.rst    (rst),
		.load   (load),
		.sum_0  (sum_0),
		.sum_1  (sum_1),
		.sum_2  (sum_2),
		.sum_3  (sum_3),
		.sum_4  (sum_4),
		.sum_5  (sum_5),
		.sum_6  (sum_6),
		.sum_7  (sum_7),
		.coef_0 (coef_0),
		.coef_1 (coef_1),
		.coef_2 (coef_2),
		.coef_3 (coef_3),
		.coef_4 (coef_4),
		.coef_5 (coef_5),
		.coef_6 (coef_6),
		.coef_7 (coef_7)
	);

endmodule

`default_nettype wire

// ==== verification/tb_dct_row.sv ====
// Testbench for the DCT row pass: streams pixel rows into the DUT and
// checks every reported row against a floating-point built weight matrix
`timescale 1ns/100ps
`default_nettype none

module tb_dct_row;

	typedef logic [7:0][7:0]  pixel_vec_t;
	typedef logic [7:0][12:0] coef_vec_t;

	logic            clk;
	logic            rst;
	logic            enable;
	dct_pkg::pixel_t data_in;
	dct_pkg::coef_t  coef_0, coef_1, coef_2, coef_3;
	dct_pkg::coef_t  coef_4, coef_5, coef_6, coef_7;
	logic            row_valid;
	dct_pkg::idx_t   row_index;
	logic            busy;

	int        weight_m [8][8];
	int        dut_coef [8];
	coef_vec_t exp_coef_q [$];
	int        exp_row_q [$];
	int        exp_edge_q [$];
	int        edge_count = 0;
	int        next_row = 0;
	string     test_name = "reset";

	dct_row_top dut (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.data_in   (data_in),
		.coef_0    (coef_0),
		.coef_1    (coef_1),
		.coef_2    (coef_2),
		.coef_3    (coef_3),
		.coef_4    (coef_4),
		.coef_5    (coef_5),
		.coef_6    (coef_6),
		.coef_7    (coef_7),
		.row_valid (row_valid),
		.row_index (row_index),
		.busy      (busy)
	);

	assign dut_coef[0] = int'(coef_0);
	assign dut_coef[1] = int'(coef_1);
	assign dut_coef[2] = int'(coef_2);
	assign dut_coef[3] = int'(coef_3);
	assign dut_coef[4] = int'(coef_4);
	assign dut_coef[5] = int'(coef_5);
	assign dut_coef[6] = int'(coef_6);
	assign dut_coef[7] = int'(coef_7);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) edge_count <= edge_count + 1;

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			report_failure("value check failed");
		end
	endtask

	// Orthonormal DCT-II matrix scaled by 2^14 and rounded to the nearest integer
	task automatic build_weights();
		real pi;
		real c;
		real v;
		pi = $acos(-1.0);
		for (int k = 0; k < 8; k++) begin
			for (int n = 0; n < 8; n++) begin
				c = (k == 0) ? $sqrt(0.125) : 0.5;
				v = c * $cos((2.0 * n + 1.0) * k * pi / 16.0) * 16384.0;
				weight_m[k][n] = (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
			end
		end
	endtask

	function automatic coef_vec_t dct_reference(input pixel_vec_t px);
		coef_vec_t res;
		int s;
		for (int k = 0; k < 8; k++) begin
			s = 0;
			for (int n = 0; n < 8; n++) begin
				s = s + int'(px[n]) * weight_m[k][n];
			end
			if (k == 0) begin
				s = s - int'(dct_pkg::LEVEL_SHIFT_SUM);
			end
			s = (s + (1 << (dct_pkg::FRAC_BITS - 1))) >>> dct_pkg::FRAC_BITS;
			res[k] = s[12:0];
		end
		return res;
	endfunction

	function automatic pixel_vec_t random_row();
		pixel_vec_t px;
		for (int n = 0; n < 8; n++) begin
			px[n] = 8'($urandom());
		end
		return px;
	endfunction

	function automatic pixel_vec_t fill_row(input logic [7:0] value);
		pixel_vec_t px;
		for (int n = 0; n < 8; n++) begin
			px[n] = value;
		end
		return px;
	endfunction

	// A complete row is due on the third edge counted from the current falling edge
	task automatic stream_pixels(input pixel_vec_t px, input int count);
		for (int n = 0; n < count; n++) begin
			@(negedge clk);
			enable = 1'b1;
			data_in = px[n];
		end
		if (count == 8) begin
			exp_coef_q.push_back(dct_reference(px));
			exp_row_q.push_back(next_row);
			exp_edge_q.push_back(edge_count + 3);
			next_row = (next_row + 1) % 8;
		end
	endtask

	task automatic stop_stream();
		@(negedge clk);
		enable = 1'b0;
		data_in = '0;
		next_row = 0;
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while ((exp_row_q.size() != 0 || busy) && t < 100) begin
			@(negedge clk);
			t++;
		end
		if (exp_row_q.size() != 0 || busy) begin
			report_failure("timed out waiting for the pipeline to drain");
		end
	endtask

	task automatic check_flat_outputs(input string name, input int dc);
		check_value({name, " lane 0"}, dc, dut_coef[0]);
		for (int k = 1; k < 8; k++) begin
			check_value($sformatf("%s lane %0d", name, k), 0, dut_coef[k]);
		end
	endtask

	initial begin
		coef_vec_t exp_coef;
		int exp_row;
		int exp_edge;
		forever begin
			@(negedge clk);
			if (!rst && row_valid) begin
				if (exp_row_q.size() == 0) begin
					report_failure("row_valid pulsed with no complete row outstanding");
				end else begin
					exp_coef = exp_coef_q.pop_front();
					exp_row = exp_row_q.pop_front();
					exp_edge = exp_edge_q.pop_front();
					for (int k = 0; k < 8; k++) begin
						check_value($sformatf("%s lane %0d", test_name, k),
							int'($signed(exp_coef[k])), dut_coef[k]);
					end
					check_value({test_name, " row_index"}, exp_row, int'(row_index));
					check_value({test_name, " row_valid edge"}, exp_edge, edge_count);
				end
			end
		end
	end

	initial begin
		int t;
		logic got;
		rst = 1'b1;
		enable = 1'b0;
		data_in = '0;
		void'($urandom(32'h6b35));
		build_weights();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		@(negedge clk);
		check_value("reset row_valid", 0, int'(row_valid));
		check_value("reset busy", 0, int'(busy));
		check_value("reset row_index", 0, int'(row_index));
		check_flat_outputs("reset", 0);

		// Two whole blocks without a gap
		test_name = "random blocks";
		for (int r = 0; r < 16; r++) begin
			stream_pixels(random_row(), 8);
		end
		stop_stream();
		wait_drained();

		// Mid-grey cancels the level shift; black and white hit the DC extremes
		test_name = "flat 128";
		stream_pixels(fill_row(8'd128), 8);
		stop_stream();
		wait_drained();
		check_flat_outputs(test_name, 0);
		test_name = "flat 0";
		stream_pixels(fill_row(8'd0), 8);
		stop_stream();
		wait_drained();
		check_flat_outputs(test_name, -1448);
		test_name = "flat 255";
		stream_pixels(fill_row(8'd255), 8);
		stop_stream();
		wait_drained();
		check_flat_outputs(test_name, 1437);

		test_name = "partial row";
		stream_pixels(random_row(), 8);
		stream_pixels(random_row(), 8);
		stream_pixels(random_row(), 5);
		stop_stream();
		wait_drained();
		stream_pixels(random_row(), 8);
		stop_stream();
		wait_drained();

		test_name = "drain busy";
		stream_pixels(random_row(), 8);
		stop_stream();
		got = 1'b0;
		t = 0;
		while (!got && t < 20) begin
			@(negedge clk);
			check_value("busy before row_valid", 1, int'(busy));
			got = row_valid;
			t++;
		end
		if (!got) begin
			report_failure("timed out waiting for row_valid after the last row");
		end
		@(negedge clk);
		check_value("busy after row_valid", 0, int'(busy));

		t = 0;
		while (exp_row_q.size() != 0 && t < 100) begin
			@(negedge clk);
			t++;
		end
		if (exp_row_q.size() != 0) begin
			report_failure($sformatf("%0d expected rows were never reported", exp_row_q.size()));
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/dct_pkg.sv
source/pixel_counter.sv
source/row_sequencer.sv
source/dct_weight_table.sv
source/mac_bank.sv
source/coef_round.sv
source/dct_row_top.sv
verification/tb_dct_row.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the DCT row pass testbench with Verilator and runs it.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
	--top-module tb_dct_row \
	--Mdir obj_dir \
	-o tb_dct_row \
	-f vlog.f

./obj_dir/tb_dct_row
